/* hdl/rvv_cfg_pkg.sv */
// Sizes of the vector multiply back end: datapath, uop station and result ports
// Referenced by scoped name from the RTL

`default_nettype none

package rvv_cfg_pkg;

  // Datapath
  localparam int VLEN      = 128;
  localparam int SEW       = 32;
  localparam int NUM_ELEM  = VLEN / SEW;
  localparam int ROB_IDX_W = 5;
  localparam int FUNCT6_W  = 6;

  // Station and result ports
  localparam int RS_DEPTH  = 4;
  localparam int RS_PTR_W  = $clog2(RS_DEPTH);
  localparam int NUM_MUL   = 2;
  localparam int NUM_PORT  = 2;

endpackage

`default_nettype wire

/* hdl/rvv_lane_mul.sv */
// One SEW-wide element multiplier with a full double-width product
// Each operand is sign- or zero-extended by one bit as its flag says

`default_nettype none

module rvv_lane_mul (
  input  wire [rvv_cfg_pkg::SEW-1:0]    a,
  input  wire [rvv_cfg_pkg::SEW-1:0]    b,
  input  wire                           a_signed,
  input  wire                           b_signed,
  output logic [2*rvv_cfg_pkg::SEW-1:0] product
);

  logic signed [rvv_cfg_pkg::SEW:0]     a_ext;
  logic signed [rvv_cfg_pkg::SEW:0]     b_ext;
  logic signed [2*rvv_cfg_pkg::SEW+1:0] full;

  // The extra bit holds both signed and unsigned ranges
  assign a_ext = {a_signed & a[rvv_cfg_pkg::SEW-1], a};
  assign b_ext = {b_signed & b[rvv_cfg_pkg::SEW-1], b};
  assign full = a_ext * b_ext;

  // Top two bits only repeat the sign
  assign product = full[2*rvv_cfg_pkg::SEW-1:0];

endmodule

`default_nettype wire

/* hdl/rvv_mac_unit.sv */
// MAC execution unit: the four multiplies plus vmacc, vnmsac, vmadd, vnmsub
// Accumulates keep the low SEW bits; result registered and held like the MUL unit

`default_nettype none

module rvv_mac_unit (
  input  wire                                 clk,
  input  wire                                 arst_n,
  input  wire                                 issue_valid,
  input  wire [rvv_cfg_pkg::FUNCT6_W-1:0]     funct6,
  input  wire [rvv_cfg_pkg::VLEN-1:0]         vs2,
  input  wire [rvv_cfg_pkg::VLEN-1:0]         vs1,
  input  wire [rvv_cfg_pkg::VLEN-1:0]         vd,
  input  wire [rvv_cfg_pkg::ROB_IDX_W-1:0]    rob_idx,
  input  wire                                 out_ready,
  output logic                                out_valid,
  output logic [rvv_cfg_pkg::VLEN-1:0]        out_data,
  output logic [rvv_cfg_pkg::ROB_IDX_W-1:0]   out_rob_idx
);

  localparam int W = rvv_cfg_pkg::SEW;

  logic [rvv_cfg_pkg::VLEN-1:0] result;
  logic                         a_signed;
  logic                         b_signed;
  logic                         use_vd;

  assign a_signed = rvv_uop_pkg::vs2_signed(funct6);
  assign b_signed = rvv_uop_pkg::vs1_signed(funct6);
  // vmadd and vnmsub multiply by the old destination
  assign use_vd = funct6 inside {rvv_uop_pkg::F6_VMADD, rvv_uop_pkg::F6_VNMSUB};

  for (genvar i = 0; i < rvv_cfg_pkg::NUM_ELEM; i++) begin : g_lane
    logic [2*W-1:0] product;
    logic [W-1:0]   vs2_e;
    logic [W-1:0]   vd_e;
    logic [W-1:0]   elem;

    assign vs2_e = vs2[i*W +: W];
    assign vd_e  = vd[i*W +: W];

    rvv_lane_mul u_lane (
      .a        (use_vd ? vd_e : vs2_e),
      .b        (vs1[i*W +: W]),
      .a_signed (a_signed),
      .b_signed (b_signed),
      .product  (product)
    );

    always_comb begin
      case (funct6)
        rvv_uop_pkg::F6_VMACC:  elem = product[W-1:0] + vd_e;
        rvv_uop_pkg::F6_VNMSAC: elem = vd_e - product[W-1:0];
        rvv_uop_pkg::F6_VMADD:  elem = product[W-1:0] + vs2_e;
        rvv_uop_pkg::F6_VNMSUB: elem = vs2_e - product[W-1:0];
        rvv_uop_pkg::F6_VMUL:   elem = product[W-1:0];
        default:                elem = product[2*W-1:W];
      endcase
    end

    assign result[i*W +: W] = elem;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid <= 1'b0;
    end else if (issue_valid) begin
      out_valid <= 1'b1;
    end else if (out_ready) begin
      out_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (issue_valid) begin
      out_data    <= result;
      out_rob_idx <= rob_idx;
    end
  end

endmodule

`default_nettype wire

/* hdl/rvv_mul_rs.sv */
// In-order reservation station for multiply uops
// One push port, the two oldest entries visible at once, pop of one or two per cycle

`default_nettype none

module rvv_mul_rs (
  input  wire                                                     clk,
  input  wire                                                     arst_n,
  input  wire                                                     in_valid,
  output logic                                                    in_ready,
  input  wire [rvv_cfg_pkg::FUNCT6_W-1:0]                         in_funct6,
  input  wire [rvv_cfg_pkg::VLEN-1:0]                             in_vs2,
  input  wire [rvv_cfg_pkg::VLEN-1:0]                             in_vs1,
  input  wire [rvv_cfg_pkg::VLEN-1:0]                             in_vd,
  input  wire [rvv_cfg_pkg::ROB_IDX_W-1:0]                        in_rob_idx,
  output logic [rvv_cfg_pkg::NUM_MUL-1:0][rvv_cfg_pkg::FUNCT6_W-1:0]  head_funct6,
  output logic [rvv_cfg_pkg::NUM_MUL-1:0][rvv_cfg_pkg::VLEN-1:0]      head_vs2,
  output logic [rvv_cfg_pkg::NUM_MUL-1:0][rvv_cfg_pkg::VLEN-1:0]      head_vs1,
  output logic [rvv_cfg_pkg::NUM_MUL-1:0][rvv_cfg_pkg::VLEN-1:0]      head_vd,
  output logic [rvv_cfg_pkg::NUM_MUL-1:0][rvv_cfg_pkg::ROB_IDX_W-1:0] head_rob_idx,
  output logic                                                    rs_empty,
  output logic                                                    rs_one_left,
  input  wire [rvv_cfg_pkg::NUM_MUL-1:0]                          rs_pop
);

  localparam int PW = rvv_cfg_pkg::RS_PTR_W;

  logic [rvv_cfg_pkg::FUNCT6_W-1:0]  mem_funct6  [rvv_cfg_pkg::RS_DEPTH];
  logic [rvv_cfg_pkg::VLEN-1:0]      mem_vs2     [rvv_cfg_pkg::RS_DEPTH];
  logic [rvv_cfg_pkg::VLEN-1:0]      mem_vs1     [rvv_cfg_pkg::RS_DEPTH];
  logic [rvv_cfg_pkg::VLEN-1:0]      mem_vd      [rvv_cfg_pkg::RS_DEPTH];
  logic [rvv_cfg_pkg::ROB_IDX_W-1:0] mem_rob_idx [rvv_cfg_pkg::RS_DEPTH];

  logic [PW-1:0] rd_ptr;
  logic [PW-1:0] wr_ptr;
  logic [PW:0]   count;
  logic [PW:0]   pop_num;
  logic          push;

  assign in_ready    = count != rvv_cfg_pkg::RS_DEPTH;
  assign push        = in_valid && in_ready;
  assign rs_empty    = count == '0;
  assign rs_one_left = count == 1;

  always_comb begin
    pop_num = '0;
    for (int i = 0; i < rvv_cfg_pkg::NUM_MUL; i++) begin
      pop_num = pop_num + rs_pop[i];
    end
  end

  // Pointers wrap naturally with a power-of-two depth
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      rd_ptr <= rd_ptr + pop_num[PW-1:0];
      wr_ptr <= wr_ptr + {{(PW-1){1'b0}}, push};
      count  <= count + {{PW{1'b0}}, push} - pop_num;
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem_funct6[wr_ptr]  <= in_funct6;
      mem_vs2[wr_ptr]     <= in_vs2;
      mem_vs1[wr_ptr]     <= in_vs1;
      mem_vd[wr_ptr]      <= in_vd;
      mem_rob_idx[wr_ptr] <= in_rob_idx;
    end
  end

  // Head i is the i-th oldest entry
  for (genvar i = 0; i < rvv_cfg_pkg::NUM_MUL; i++) begin : g_head
    logic [PW-1:0] idx;

    assign idx = rd_ptr + (PW)'(i);
    assign head_funct6[i]  = mem_funct6[idx];
    assign head_vs2[i]     = mem_vs2[idx];
    assign head_vs1[i]     = mem_vs1[idx];
    assign head_vd[i]      = mem_vd[idx];
    assign head_rob_idx[i] = mem_rob_idx[idx];
  end

endmodule

`default_nettype wire

/* hdl/rvv_mul_unit.sv */
// MUL execution unit: vmul, vmulh, vmulhu and vmulhsu on all elements
// Result is registered one cycle after issue and held until taken

`default_nettype none

module rvv_mul_unit (
  input  wire                                 clk,
  input  wire                                 arst_n,
  input  wire                                 issue_valid,
  input  wire [rvv_cfg_pkg::FUNCT6_W-1:0]     funct6,
  input  wire [rvv_cfg_pkg::VLEN-1:0]         vs2,
  input  wire [rvv_cfg_pkg::VLEN-1:0]         vs1,
  input  wire [rvv_cfg_pkg::ROB_IDX_W-1:0]    rob_idx,
  input  wire                                 out_ready,
  output logic                                out_valid,
  output logic [rvv_cfg_pkg::VLEN-1:0]        out_data,
  output logic [rvv_cfg_pkg::ROB_IDX_W-1:0]   out_rob_idx
);

  localparam int W = rvv_cfg_pkg::SEW;

  logic [rvv_cfg_pkg::VLEN-1:0] result;
  logic                         a_signed;
  logic                         b_signed;
  logic                         high;

  assign a_signed = rvv_uop_pkg::vs2_signed(funct6);
  assign b_signed = rvv_uop_pkg::vs1_signed(funct6);
  assign high = rvv_uop_pkg::take_high(funct6);

  for (genvar i = 0; i < rvv_cfg_pkg::NUM_ELEM; i++) begin : g_lane
    logic [2*W-1:0] product;

    rvv_lane_mul u_lane (
      .a        (vs2[i*W +: W]),
      .b        (vs1[i*W +: W]),
      .a_signed (a_signed),
      .b_signed (b_signed),
      .product  (product)
    );

    assign result[i*W +: W] = high ? product[2*W-1:W] : product[W-1:0];
  end

  // A new issue wins over a transfer of the held result
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid <= 1'b0;
    end else if (issue_valid) begin
      out_valid <= 1'b1;
    end else if (out_ready) begin
      out_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (issue_valid) begin
      out_data    <= result;
      out_rob_idx <= rob_idx;
    end
  end

endmodule

`default_nettype wire

/* hdl/rvv_mulmac.sv */
// MUL/MAC execution wrapper: steers the two head uops to the MUL and MAC units
// and pops the station in order; port 0 carries MUL results, port 1 MAC results

`default_nettype none

module rvv_mulmac (
  input  wire                                                     clk,
  input  wire                                                     arst_n,
  input  wire [rvv_cfg_pkg::NUM_MUL-1:0][rvv_cfg_pkg::FUNCT6_W-1:0]   head_funct6,
  input  wire [rvv_cfg_pkg::NUM_MUL-1:0][rvv_cfg_pkg::VLEN-1:0]       head_vs2,
  input  wire [rvv_cfg_pkg::NUM_MUL-1:0][rvv_cfg_pkg::VLEN-1:0]       head_vs1,
  input  wire [rvv_cfg_pkg::NUM_MUL-1:0][rvv_cfg_pkg::VLEN-1:0]       head_vd,
  input  wire [rvv_cfg_pkg::NUM_MUL-1:0][rvv_cfg_pkg::ROB_IDX_W-1:0]  head_rob_idx,
  input  wire                                                     rs_empty,
  input  wire                                                     rs_one_left,
  output logic [rvv_cfg_pkg::NUM_MUL-1:0]                         rs_pop,
  output wire [rvv_cfg_pkg::NUM_PORT-1:0]                         out_valid,
  output wire [rvv_cfg_pkg::NUM_PORT-1:0][rvv_cfg_pkg::VLEN-1:0]  out_data,
  output wire [rvv_cfg_pkg::NUM_PORT-1:0][rvv_cfg_pkg::ROB_IDX_W-1:0] out_rob_idx,
  input  wire [rvv_cfg_pkg::NUM_PORT-1:0]                         out_ready
);

  logic [rvv_cfg_pkg::NUM_MUL-1:0] uop_valid;
  logic [rvv_cfg_pkg::NUM_MUL-1:0] uop_is_mac;
  logic [rvv_cfg_pkg::NUM_MUL-1:0] uop_ready;
  logic                            mul_sel;
  logic                            mac_sel;
  logic                            mac_pair;
  logic                            mul_ready;
  logic                            mac_ready;

  // empty / one_left -> 0, 1 or at least 2 heads valid
  assign uop_valid[0] = !rs_empty;
  assign uop_valid[1] = !rs_empty && !rs_one_left;

  for (genvar i = 0; i < rvv_cfg_pkg::NUM_MUL; i++) begin : g_dec
    assign uop_is_mac[i] = uop_valid[i] && rvv_uop_pkg::is_mac(head_funct6[i]);
  end

  // MAC unit takes head 0 when it accumulates, else head 1
  assign mul_sel  = uop_is_mac[0];
  assign mac_sel  = !uop_is_mac[0];
  // Two accumulates in a row: head 1 waits
  assign mac_pair = &uop_is_mac;

  // A unit can take a uop when its result slot frees this cycle
  assign mul_ready = !out_valid[0] || out_ready[0];
  assign mac_ready = !out_valid[1] || out_ready[1];

  always_comb begin
    uop_ready = '0;
    uop_ready[mac_sel] = mac_ready;
    uop_ready[mul_sel] = mul_ready && !mac_pair;
  end

  // Head 1 never leaves ahead of head 0
  assign rs_pop[0] = uop_valid[0] && uop_ready[0];
  assign rs_pop[1] = uop_valid[1] && uop_ready[1] && rs_pop[0];

  // Issue goes with the pop of the steered head
  rvv_mul_unit u_mul (
    .clk         (clk),
    .arst_n      (arst_n),
    .issue_valid (rs_pop[mul_sel]),
    .funct6      (head_funct6[mul_sel]),
    .vs2         (head_vs2[mul_sel]),
    .vs1         (head_vs1[mul_sel]),
    .rob_idx     (head_rob_idx[mul_sel]),
    .out_ready   (out_ready[0]),
    .out_valid   (out_valid[0]),
    .out_data    (out_data[0]),
    .out_rob_idx (out_rob_idx[0])
  );

  rvv_mac_unit u_mac (
    .clk         (clk),
    .arst_n      (arst_n),
    .issue_valid (rs_pop[mac_sel]),
    .funct6      (head_funct6[mac_sel]),
    .vs2         (head_vs2[mac_sel]),
    .vs1         (head_vs1[mac_sel]),
    .vd          (head_vd[mac_sel]),
    .rob_idx     (head_rob_idx[mac_sel]),
    .out_ready   (out_ready[1]),
    .out_valid   (out_valid[1]),
    .out_data    (out_data[1]),
    .out_rob_idx (out_rob_idx[1])
  );

endmodule

`default_nettype wire

/* hdl/rvv_mulmac_top.sv */
// Vector multiply back end: uop station feeding the MUL/MAC wrapper
// Push uops on the in_ port; results leave on two independent valid/ready ports

`default_nettype none

module rvv_mulmac_top (
  input  wire                                                     clk,
  input  wire                                                     arst_n,
  input  wire                                                     in_valid,
  output wire                                                     in_ready,
  input  wire [rvv_cfg_pkg::FUNCT6_W-1:0]                         in_funct6,
  input  wire [rvv_cfg_pkg::VLEN-1:0]                             in_vs2,
  input  wire [rvv_cfg_pkg::VLEN-1:0]                             in_vs1,
  input  wire [rvv_cfg_pkg::VLEN-1:0]                             in_vd,
  input  wire [rvv_cfg_pkg::ROB_IDX_W-1:0]                        in_rob_idx,
  output wire [rvv_cfg_pkg::NUM_PORT-1:0]                         out_valid,
  output wire [rvv_cfg_pkg::NUM_PORT-1:0][rvv_cfg_pkg::VLEN-1:0]  out_data,
  output wire [rvv_cfg_pkg::NUM_PORT-1:0][rvv_cfg_pkg::ROB_IDX_W-1:0] out_rob_idx,
  input  wire [rvv_cfg_pkg::NUM_PORT-1:0]                         out_ready
);

  wire [rvv_cfg_pkg::NUM_MUL-1:0][rvv_cfg_pkg::FUNCT6_W-1:0]  head_funct6;
  wire [rvv_cfg_pkg::NUM_MUL-1:0][rvv_cfg_pkg::VLEN-1:0]      head_vs2;
  wire [rvv_cfg_pkg::NUM_MUL-1:0][rvv_cfg_pkg::VLEN-1:0]      head_vs1;
  wire [rvv_cfg_pkg::NUM_MUL-1:0][rvv_cfg_pkg::VLEN-1:0]      head_vd;
  wire [rvv_cfg_pkg::NUM_MUL-1:0][rvv_cfg_pkg::ROB_IDX_W-1:0] head_rob_idx;
  wire                                                        rs_empty;
  wire                                                        rs_one_left;
  wire [rvv_cfg_pkg::NUM_MUL-1:0]                             rs_pop;

  rvv_mul_rs u_rs (
    .clk          (clk),
    .arst_n       (arst_n),
    .in_valid     (in_valid),
    .in_ready     (in_ready),
    .in_funct6    (in_funct6),
    .in_vs2       (in_vs2),
    .in_vs1       (in_vs1),
    .in_vd        (in_vd),
    .in_rob_idx   (in_rob_idx),
    .head_funct6  (head_funct6),
    .head_vs2     (head_vs2),
    .head_vs1     (head_vs1),
    .head_vd      (head_vd),
    .head_rob_idx (head_rob_idx),
    .rs_empty     (rs_empty),
    .rs_one_left  (rs_one_left),
    .rs_pop       (rs_pop)
  );

  rvv_mulmac u_mulmac (
    .clk          (clk),
    .arst_n       (arst_n),
    .head_funct6  (head_funct6),
    .head_vs2     (head_vs2),
    .head_vs1     (head_vs1),
    .head_vd      (head_vd),
    .head_rob_idx (head_rob_idx),
    .rs_empty     (rs_empty),
    .rs_one_left  (rs_one_left),
    .rs_pop       (rs_pop),
    .out_valid    (out_valid),
    .out_data     (out_data),
    .out_rob_idx  (out_rob_idx),
    .out_ready    (out_ready)
  );

endmodule

`default_nettype wire

/* hdl/rvv_uop_pkg.sv */
// funct6 encodings of the supported vector multiply ops, plus decode helpers
// shared by the wrapper and both execution units

`default_nettype none

package rvv_uop_pkg;

  localparam logic [rvv_cfg_pkg::FUNCT6_W-1:0] F6_VMUL    = 6'b100101;
  localparam logic [rvv_cfg_pkg::FUNCT6_W-1:0] F6_VMULH   = 6'b100111;
  localparam logic [rvv_cfg_pkg::FUNCT6_W-1:0] F6_VMULHU  = 6'b100100;
  localparam logic [rvv_cfg_pkg::FUNCT6_W-1:0] F6_VMULHSU = 6'b100110;
  localparam logic [rvv_cfg_pkg::FUNCT6_W-1:0] F6_VMACC   = 6'b101101;
  localparam logic [rvv_cfg_pkg::FUNCT6_W-1:0] F6_VNMSAC  = 6'b101111;
  localparam logic [rvv_cfg_pkg::FUNCT6_W-1:0] F6_VMADD   = 6'b101001;
  localparam logic [rvv_cfg_pkg::FUNCT6_W-1:0] F6_VNMSUB  = 6'b101011;

  // Accumulate forms need the MAC unit
  function automatic logic is_mac(input logic [rvv_cfg_pkg::FUNCT6_W-1:0] f6);
    return f6 inside {F6_VMACC, F6_VNMSAC, F6_VMADD, F6_VNMSUB};
  endfunction

  function automatic logic vs2_signed(input logic [rvv_cfg_pkg::FUNCT6_W-1:0] f6);
    return f6 inside {F6_VMULH, F6_VMULHSU};
  endfunction

  function automatic logic vs1_signed(input logic [rvv_cfg_pkg::FUNCT6_W-1:0] f6);
    return f6 == F6_VMULH;
  endfunction

  // High half of the product
  function automatic logic take_high(input logic [rvv_cfg_pkg::FUNCT6_W-1:0] f6);
    return f6 inside {F6_VMULH, F6_VMULHU, F6_VMULHSU};
  endfunction

endpackage

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build and run the testbench with Verilator; the log decides pass or fail
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_rvv_mulmac_top -f rvv_mulmac.f
status=0
./obj_dir/Vtb_rvv_mulmac_top > sim.log 2>&1 || status=$?
cat sim.log
if grep -q '\*\* FAIL \*\*' sim.log || [ "$status" -ne 0 ]; then
  echo "simulation failed"
  exit 1
fi
echo "simulation passed"

/* rvv_mulmac.f */
hdl/rvv_cfg_pkg.sv
hdl/rvv_uop_pkg.sv
hdl/rvv_lane_mul.sv
hdl/rvv_mul_unit.sv
hdl/rvv_mac_unit.sv
hdl/rvv_mul_rs.sv
hdl/rvv_mulmac.sv
hdl/rvv_mulmac_top.sv
sim/tb_rvv_mulmac_top.sv

/* sim/tb_rvv_mulmac_top.sv */
// Directed testbench for the vector multiply back end
// Pushes uops, models every result by rob_idx and checks both result ports on transfer

`default_nettype none

module tb_rvv_mulmac_top;

  localparam int W              = rvv_cfg_pkg::SEW;
  localparam int TIMEOUT_CYCLES = 2000;

  logic                                  clk;
  logic                                  arst_n;
  logic                                  in_valid;
  wire                                   in_ready;
  logic [rvv_cfg_pkg::FUNCT6_W-1:0]      in_funct6;
  logic [rvv_cfg_pkg::VLEN-1:0]          in_vs2;
  logic [rvv_cfg_pkg::VLEN-1:0]          in_vs1;
  logic [rvv_cfg_pkg::VLEN-1:0]          in_vd;
  logic [rvv_cfg_pkg::ROB_IDX_W-1:0]     in_rob_idx;
  wire  [rvv_cfg_pkg::NUM_PORT-1:0]      out_valid;
  wire  [rvv_cfg_pkg::NUM_PORT-1:0][rvv_cfg_pkg::VLEN-1:0]      out_data;
  wire  [rvv_cfg_pkg::NUM_PORT-1:0][rvv_cfg_pkg::ROB_IDX_W-1:0] out_rob_idx;
  logic [rvv_cfg_pkg::NUM_PORT-1:0]      out_ready;

  // Expected results, indexed by rob_idx
  logic [rvv_cfg_pkg::VLEN-1:0]          exp_data [32];
  bit                                    exp_mac  [32];
  bit                                    pending  [32];
  int                                    exp_seq  [32];
  int                                    last_seq [rvv_cfg_pkg::NUM_PORT];
  logic [rvv_cfg_pkg::ROB_IDX_W-1:0]     next_rob;
  int                                    push_cnt;
  int                                    recv_cnt;
  int                                    cycle_cnt;

  rvv_mulmac_top UUT (
    .clk         (clk),
    .arst_n      (arst_n),
    .in_valid    (in_valid),
    .in_ready    (in_ready),
    .in_funct6   (in_funct6),
    .in_vs2      (in_vs2),
    .in_vs1      (in_vs1),
    .in_vd       (in_vd),
    .in_rob_idx  (in_rob_idx),
    .out_valid   (out_valid),
    .out_data    (out_data),
    .out_rob_idx (out_rob_idx),
    .out_ready   (out_ready)
  );

  always #10 clk = ~clk;

  task automatic abort_run(input string line);
    $display("%s", line);
    $display("** FAIL **");
    $fatal(1);
  endtask

  // One element by the RVV rules; a is vs2, b is vs1, c is the old vd
  function automatic logic [W-1:0] ref_elem(input logic [rvv_cfg_pkg::FUNCT6_W-1:0] f6,
                                            input logic [W-1:0] a, b, c);
    logic [2*W-1:0] sa;
    logic [2*W-1:0] sb;
    logic [2*W-1:0] ua;
    logic [2*W-1:0] ub;
    logic [2*W-1:0] p;
    sa = {{W{a[W-1]}}, a};
    sb = {{W{b[W-1]}}, b};
    ua = {{W{1'b0}}, a};
    ub = {{W{1'b0}}, b};
    case (f6)
      rvv_uop_pkg::F6_VMUL:    return a * b;
      rvv_uop_pkg::F6_VMULH: begin
        p = sa * sb;
        return p[2*W-1:W];
      end
      rvv_uop_pkg::F6_VMULHU: begin
        p = ua * ub;
        return p[2*W-1:W];
      end
      rvv_uop_pkg::F6_VMULHSU: begin
        p = sa * ub;
        return p[2*W-1:W];
      end
      rvv_uop_pkg::F6_VMACC:   return b * a + c;
      rvv_uop_pkg::F6_VNMSAC:  return c - b * a;
      rvv_uop_pkg::F6_VMADD:   return b * c + a;
      rvv_uop_pkg::F6_VNMSUB:  return a - b * c;
      default:                 return 'x;
    endcase
  endfunction

  function automatic logic [rvv_cfg_pkg::VLEN-1:0] ref_vec(
      input logic [rvv_cfg_pkg::FUNCT6_W-1:0] f6,
      input logic [rvv_cfg_pkg::VLEN-1:0] vs2, vs1, vd);
    logic [rvv_cfg_pkg::VLEN-1:0] r;
    r = '0;
    for (int i = 0; i < rvv_cfg_pkg::NUM_ELEM; i++) begin
      r[i*W +: W] = ref_elem(f6, vs2[i*W +: W], vs1[i*W +: W], vd[i*W +: W]);
    end
    return r;
  endfunction

  function automatic logic [rvv_cfg_pkg::VLEN-1:0] rand_vec();
    return {$urandom, $urandom, $urandom, $urandom};
  endfunction

  // Called right after a rising edge; records the expectation and presents the uop
  task automatic drive_uop(input logic [rvv_cfg_pkg::FUNCT6_W-1:0] f6,
                           input logic [rvv_cfg_pkg::VLEN-1:0] vs2, vs1, vd);
    assert (!pending[next_rob])
      else abort_run("testbench reused a rob_idx that still waits for its result");
    exp_data[next_rob] = ref_vec(f6, vs2, vs1, vd);
    exp_mac[next_rob]  = f6 inside {rvv_uop_pkg::F6_VMACC, rvv_uop_pkg::F6_VNMSAC,
                                    rvv_uop_pkg::F6_VMADD, rvv_uop_pkg::F6_VNMSUB};
    exp_seq[next_rob]  = push_cnt;
    pending[next_rob]  = 1'b1;
    in_valid   <= 1'b1;
    in_funct6  <= f6;
    in_vs2     <= vs2;
    in_vs1     <= vs1;
    in_vd      <= vd;
    in_rob_idx <= next_rob;
    next_rob = next_rob + 1'b1;
    push_cnt++;
  endtask

  // Returns at the edge where the push transferred
  task automatic wait_accept();
    do @(posedge clk); while (!in_ready);
  endtask

  task automatic push_uop(input logic [rvv_cfg_pkg::FUNCT6_W-1:0] f6,
                          input logic [rvv_cfg_pkg::VLEN-1:0] vs2, vs1, vd);
    drive_uop(f6, vs2, vs1, vd);
    wait_accept();
  endtask

  task automatic wait_drain();
    in_valid <= 1'b0;
    while (recv_cnt != push_cnt) @(posedge clk);
    @(posedge clk);
  endtask

  task automatic check_result(input int p);
    logic [rvv_cfg_pkg::ROB_IDX_W-1:0] r;
    r = out_rob_idx[p];
    assert (pending[r])
      else abort_run($sformatf("error at %0t: port %0d returned rob_idx %0d not outstanding",
                               $time, p, r));
    assert (out_data[p] == exp_data[r])
      else abort_run($sformatf("error at %0t: port %0d rob_idx %0d data %h, expected %h",
                               $time, p, r, out_data[p], exp_data[r]));
    assert (!exp_mac[r] || p == 1)
      else abort_run($sformatf("error at %0t: accumulate rob_idx %0d left on port %0d",
                               $time, r, p));
    assert (exp_seq[r] > last_seq[p])
      else abort_run($sformatf("error at %0t: port %0d rob_idx %0d out of push order",
                               $time, p, r));
    last_seq[p] = exp_seq[r];
    pending[r]  = 1'b0;
    recv_cnt++;
  endtask

  // Result monitor, sampling values from before the edge
  always @(posedge clk) begin
    if (arst_n) begin
      for (int p = 0; p < rvv_cfg_pkg::NUM_PORT; p++) begin
        if (out_valid[p] && out_ready[p]) check_result(p);
      end
    end
  end

  // All tests together take a few hundred cycles
  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      abort_run("timeout: the tests did not finish within the cycle limit");
    end
  end

  task automatic check_reset_state();
    assert (out_valid == '0)
      else abort_run($sformatf("error at %0t: out_valid %b after reset", $time, out_valid));
    assert (in_ready)
      else abort_run($sformatf("error at %0t: in_ready low after reset", $time));
  endtask

  task automatic test_multiplies();
    logic [rvv_cfg_pkg::FUNCT6_W-1:0] ops [4];
    ops = '{rvv_uop_pkg::F6_VMUL, rvv_uop_pkg::F6_VMULH,
            rvv_uop_pkg::F6_VMULHU, rvv_uop_pkg::F6_VMULHSU};
    // Signed extremes first
    for (int i = 0; i < 4; i++) begin
      push_uop(ops[i], {32'h8000_0000, 32'h7fff_ffff, 32'hffff_ffff, 32'h0000_0001},
               {32'h8000_0000, 32'h8000_0000, 32'hffff_ffff, 32'h7fff_ffff}, rand_vec());
    end
    for (int i = 0; i < 12; i++) begin
      push_uop(ops[i % 4], rand_vec(), rand_vec(), rand_vec());
    end
    wait_drain();
  endtask

  task automatic test_accumulates();
    logic [rvv_cfg_pkg::FUNCT6_W-1:0] ops [4];
    ops = '{rvv_uop_pkg::F6_VMACC, rvv_uop_pkg::F6_VNMSAC,
            rvv_uop_pkg::F6_VMADD, rvv_uop_pkg::F6_VNMSUB};
    for (int i = 0; i < 8; i++) begin
      push_uop(ops[i % 4], rand_vec(), rand_vec(), rand_vec());
    end
    wait_drain();
  endtask

  // A held MAC result backs up the station, so the release meets
  // MAC-MAC, MAC-multiply and multiply-MAC head pairs
  task automatic test_mixed();
    logic [rvv_cfg_pkg::FUNCT6_W-1:0] ops [12];
    ops = '{rvv_uop_pkg::F6_VMACC, rvv_uop_pkg::F6_VMADD, rvv_uop_pkg::F6_VNMSAC,
            rvv_uop_pkg::F6_VMUL, rvv_uop_pkg::F6_VMULH, rvv_uop_pkg::F6_VNMSUB,
            rvv_uop_pkg::F6_VMACC, rvv_uop_pkg::F6_VMACC, rvv_uop_pkg::F6_VMULHU,
            rvv_uop_pkg::F6_VMADD, rvv_uop_pkg::F6_VNMSAC, rvv_uop_pkg::F6_VMULHSU};
    out_ready <= '0;
    for (int i = 0; i < 12; i++) begin
      // One uop in the MAC unit and a full station
      if (i == rvv_cfg_pkg::RS_DEPTH + 1) begin
        out_ready <= '1;
      end
      push_uop(ops[i], rand_vec(), rand_vec(), rand_vec());
    end
    wait_drain();
  endtask

  // MAC then MUL fill both units, then four more fill the station
  task automatic test_backpressure();
    logic [rvv_cfg_pkg::NUM_PORT-1:0][rvv_cfg_pkg::VLEN-1:0]      held_data;
    logic [rvv_cfg_pkg::NUM_PORT-1:0][rvv_cfg_pkg::ROB_IDX_W-1:0] held_rob;
    out_ready <= '0;
    push_uop(rvv_uop_pkg::F6_VMACC, rand_vec(), rand_vec(), rand_vec());
    push_uop(rvv_uop_pkg::F6_VMUL, rand_vec(), rand_vec(), rand_vec());
    for (int i = 0; i < rvv_cfg_pkg::RS_DEPTH; i++) begin
      push_uop(rvv_uop_pkg::F6_VMULHU, rand_vec(), rand_vec(), rand_vec());
    end
    drive_uop(rvv_uop_pkg::F6_VNMSUB, rand_vec(), rand_vec(), rand_vec());
    for (int c = 0; c < 10; c++) begin
      @(posedge clk);
      if (c == 0) begin
        held_data = out_data;
        held_rob  = out_rob_idx;
      end
      assert (!in_ready)
        else abort_run($sformatf("error at %0t: in_ready high with %0d uops outstanding",
                                 $time, push_cnt - recv_cnt - 1));
      assert (out_valid == '1)
        else abort_run($sformatf("error at %0t: out_valid %b dropped while held",
                                 $time, out_valid));
      assert (out_data == held_data && out_rob_idx == held_rob)
        else abort_run($sformatf("error at %0t: held result changed under back-pressure",
                                 $time));
    end
    out_ready <= '1;
    wait_accept();
    wait_drain();
  endtask

  initial begin
    clk        = 1'b0;
    arst_n     = 1'b0;
    in_valid   = 1'b0;
    in_funct6  = '0;
    in_vs2     = '0;
    in_vs1     = '0;
    in_vd      = '0;
    in_rob_idx = '0;
    out_ready  = '1;
    next_rob   = '0;
    push_cnt   = 0;
    recv_cnt   = 0;
    cycle_cnt  = 0;
    for (int i = 0; i < 32; i++) pending[i] = 1'b0;
    for (int p = 0; p < rvv_cfg_pkg::NUM_PORT; p++) last_seq[p] = -1;
    void'($urandom(32'hc8b1_835d));
    repeat (16) @(posedge clk);
    arst_n <= 1'b1;
    @(posedge clk);
    check_reset_state();
    test_multiplies();
    test_accumulates();
    test_mixed();
    test_backpressure();
    $display("** PASS **");
    $finish;
  end

endmodule

`default_nettype wire
